/* verilog/icache_cfg.svh */
// geometry of the instruction cache: address split, ways and sets
// included by the packages and by every module that sizes storage
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// fetch address split, tag | index | offset
`define ICACHE_ADDR_W   32
`define ICACHE_OFFSET_W 3   // byte within the 64-bit line
`define ICACHE_INDEX_W  6
`define ICACHE_TAG_W    23  // addr - index - offset

// organisation
`define ICACHE_WAYS     2
`define ICACHE_SETS     64  // 2**index width

`endif

/* verilog/mem_pkg.sv */
// memory-side types shared by the fetch port and the refill port
`include "icache_cfg.svh"

package mem_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [63:0]               word_t;  // one line is one word

  // read response, AXI-style encoding
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_ERR  = 2'b10;  // slave error

endpackage

/* verilog/icache_pkg.sv */
// cache-side types: address fields, tag RAM entry and way number
// referenced by scoped name from the cache modules and interfaces
`include "icache_cfg.svh"

package icache_pkg;

  // fields of a fetch address
  typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;

  // way select, one bit for two ways
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

  // contents of one tag RAM word
  typedef struct packed {
    tag_t tag;
  } tag_entry_t;

endpackage

/* verilog/icache_if.sv */
// internal buses of the cache: RAM port per way and the refill handshake
// the controller owns the ctrl/master side of both

interface sram_if #(
  parameter type entry_t = logic
);
  logic               en;
  logic               we;     // write wins over read
  icache_pkg::index_t addr;
  entry_t             wdata;
  entry_t             rdata;  // valid the cycle after a read

  modport ctrl (output en, we, addr, wdata, input rdata);
  modport ram  (input en, we, addr, wdata, output rdata);
endinterface

interface refill_if;
  logic           req;   // single-cycle pulse
  mem_pkg::addr_t addr;
  logic           done;  // single-cycle pulse, data and resp valid
  mem_pkg::word_t data;
  mem_pkg::resp_t resp;

  modport master (output req, addr, input done, data, resp);
  modport slave  (input req, addr, output done, data, resp);
endinterface

/* verilog/icache_sram.sv */
// single-port RAM with registered read, one per data way and tag way
// entry type is a parameter, depth defaults to the set count
`include "icache_cfg.svh"

module icache_sram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = `ICACHE_SETS
) (
  input logic clk,
  sram_if.ram bus
);

  entry_t mem_q [DEPTH];

  always_ff @(posedge clk) begin
    if (bus.en) begin
      if (bus.we) begin
        mem_q[bus.addr] <= bus.wdata;  // no read on a write cycle
      end else begin
        bus.rdata <= mem_q[bus.addr];  // holds until the next read
      end
    end
  end

  // an X index would read or corrupt an arbitrary set
  a_addr_known: assert property (
    @(posedge clk) bus.en |-> !$isunknown(bus.addr)
  );

endmodule

/* verilog/icache_refill.sv */
// memory read master for line refills
// one address beat out, one data beat back, done pulses a cycle after data
module icache_refill (
  input  logic           clk,
  input  logic           rst,
  refill_if.slave        rf,
  output logic           mem_ar_valid_o,
  input  logic           mem_ar_ready_i,
  output mem_pkg::addr_t mem_ar_addr_o,
  input  logic           mem_r_valid_i,
  output logic           mem_r_ready_o,
  input  mem_pkg::word_t mem_r_data_i,
  input  mem_pkg::resp_t mem_r_resp_i
);

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_e;

  state_e state_q;

  assign mem_ar_valid_o = (state_q == S_ADDR);  // held until accepted
  assign mem_r_ready_o  = (state_q == S_DATA);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      rf.done <= 1'b0;
    end else begin
      rf.done <= 1'b0;
      case (state_q)
        S_IDLE: if (rf.req) state_q <= S_ADDR;
        S_ADDR: if (mem_ar_ready_i) state_q <= S_DATA;
        S_DATA: begin
          if (mem_r_valid_i) begin
            state_q <= S_IDLE;
            rf.done <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && rf.req) mem_ar_addr_o <= rf.addr;
    if (mem_r_valid_i && mem_r_ready_o) begin
      rf.data <= mem_r_data_i;
      rf.resp <= mem_r_resp_i;
    end
  end

  // controller holds a single fetch, so never a second request in flight
  a_req_idle: assert property (
    @(posedge clk) disable iff (rst) rf.req |-> state_q == S_IDLE
  );
  a_ar_hold: assert property (
    @(posedge clk) disable iff (rst)
      (mem_ar_valid_o && !mem_ar_ready_i) |=> mem_ar_valid_o
  );

endmodule

/* verilog/icache_ctrl.sv */
// lookup and miss handling for the 2-way instruction cache
// owns the valid bits, replacement counter and the fetch handshake
`include "icache_cfg.svh"

module icache_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           fetch_valid_i,
  output logic           fetch_ready_o,
  input  mem_pkg::addr_t fetch_addr_i,
  output logic           fetch_rvalid_o,
  input  logic           fetch_rready_i,
  output mem_pkg::word_t fetch_rdata_o,
  output mem_pkg::resp_t fetch_rresp_o,
  sram_if.ctrl           data_way0,
  sram_if.ctrl           data_way1,
  sram_if.ctrl           tag_way0,
  sram_if.ctrl           tag_way1,
  refill_if.master       rf
);

  typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_REFILL, S_RESPOND} state_e;

  state_e                  state_q;
  logic                    cmp_q;  // second lookup cycle, compare registered
  mem_pkg::addr_t          req_addr_q;
  logic [`ICACHE_WAYS-1:0] valid_q [`ICACHE_SETS];
  icache_pkg::way_t        repl_q;  // free-running victim pointer
  icache_pkg::way_t        victim_q;
  icache_pkg::way_t        hit_way_q;
  logic                    hit_q;
  logic [`ICACHE_WAYS-1:0] hit;
  icache_pkg::tag_t        req_tag;
  icache_pkg::index_t      req_index;
  icache_pkg::index_t      fetch_index;
  icache_pkg::index_t      ram_addr;
  logic                    rd_en;
  logic                    fill;
  mem_pkg::word_t          hit_word;

  assign req_tag     = req_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign req_index   = req_addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign fetch_index = fetch_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

  assign hit[0] = valid_q[req_index][0] && (tag_way0.rdata.tag == req_tag);
  assign hit[1] = valid_q[req_index][1] && (tag_way1.rdata.tag == req_tag);
  assign hit_word = hit_way_q ? data_way1.rdata : data_way0.rdata;

  assign fetch_ready_o = (state_q == S_IDLE);
  assign rd_en = fetch_ready_o && fetch_valid_i;  // read both ways on accept
  assign fill  = (state_q == S_REFILL) && rf.done;
  assign ram_addr = fill ? req_index : fetch_index;

  // RAM ports, only the victim way is written
  assign data_way0.en    = rd_en || (fill && victim_q == 1'b0);
  assign data_way0.we    = fill;
  assign data_way0.addr  = ram_addr;
  assign data_way0.wdata = rf.data;
  assign data_way1.en    = rd_en || (fill && victim_q == 1'b1);
  assign data_way1.we    = fill;
  assign data_way1.addr  = ram_addr;
  assign data_way1.wdata = rf.data;
  assign tag_way0.en     = data_way0.en;
  assign tag_way0.we     = fill;
  assign tag_way0.addr   = ram_addr;
  assign tag_way0.wdata  = icache_pkg::tag_entry_t'{tag: req_tag};
  assign tag_way1.en     = data_way1.en;
  assign tag_way1.we     = fill;
  assign tag_way1.addr   = ram_addr;
  assign tag_way1.wdata  = icache_pkg::tag_entry_t'{tag: req_tag};

  // line-aligned refill address
  assign rf.addr = {req_addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], icache_pkg::offset_t'(0)};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= S_IDLE;
      cmp_q          <= 1'b0;
      fetch_rvalid_o <= 1'b0;
      rf.req         <= 1'b0;
      repl_q         <= '0;
      valid_q        <= '{default: '0};
    end else begin
      repl_q <= repl_q + 1'b1;
      rf.req <= 1'b0;
      case (state_q)
        S_IDLE: begin
          cmp_q <= 1'b0;
          if (rd_en) state_q <= S_LOOKUP;
        end
        S_LOOKUP: begin
          if (!cmp_q) begin
            cmp_q <= 1'b1;
          end else if (hit_q) begin
            fetch_rvalid_o <= 1'b1;
            state_q        <= S_RESPOND;
          end else begin
            rf.req                     <= 1'b1;
            valid_q[req_index][repl_q] <= 1'b0;  // evict before refill
            state_q                    <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (rf.done) begin
            // an error leaves the line invalid so it refetches next time
            valid_q[req_index][victim_q] <= (rf.resp == mem_pkg::RESP_OKAY);
            fetch_rvalid_o               <= 1'b1;
            state_q                      <= S_RESPOND;
          end
        end
        S_RESPOND: begin
          if (fetch_rready_i) begin
            fetch_rvalid_o <= 1'b0;
            state_q        <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) req_addr_q <= fetch_addr_i;
    if (state_q == S_LOOKUP && !cmp_q) begin
      hit_q     <= |hit;
      hit_way_q <= hit[1];
    end
    if (state_q == S_LOOKUP && cmp_q) begin
      victim_q      <= repl_q;  // only used on a miss
      fetch_rdata_o <= hit_word;
      fetch_rresp_o <= mem_pkg::RESP_OKAY;
    end
    if (fill) begin
      fetch_rdata_o <= rf.data;
      fetch_rresp_o <= rf.resp;
    end
  end

  // a set never holds the same tag valid in both ways
  a_single_hit: assert property (
    @(posedge clk) disable iff (rst)
      (state_q == S_LOOKUP && !cmp_q) |-> !(hit[0] && hit[1])
  );
  a_rdata_hold: assert property (
    @(posedge clk) disable iff (rst)
      (fetch_rvalid_o && !fetch_rready_i) |=> (fetch_rvalid_o && $stable(fetch_rdata_o))
  );

endmodule

/* verilog/icache_top.sv */
// top of the instruction cache: fetch port in, memory read port out
// wires the controller to the way RAMs and the refill master
module icache_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           fetch_valid_i,
  output logic           fetch_ready_o,
  input  mem_pkg::addr_t fetch_addr_i,
  output logic           fetch_rvalid_o,
  input  logic           fetch_rready_i,
  output mem_pkg::word_t fetch_rdata_o,
  output mem_pkg::resp_t fetch_rresp_o,
  output logic           mem_ar_valid_o,
  input  logic           mem_ar_ready_i,
  output mem_pkg::addr_t mem_ar_addr_o,
  input  logic           mem_r_valid_i,
  output logic           mem_r_ready_o,
  input  mem_pkg::word_t mem_r_data_i,
  input  mem_pkg::resp_t mem_r_resp_i
);

  sram_if #(.entry_t(mem_pkg::word_t))         data_if0 ();
  sram_if #(.entry_t(mem_pkg::word_t))         data_if1 ();
  sram_if #(.entry_t(icache_pkg::tag_entry_t)) tag_if0 ();
  sram_if #(.entry_t(icache_pkg::tag_entry_t)) tag_if1 ();
  refill_if                                    rf_if ();

  icache_ctrl i_icache_ctrl (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_rready_i (fetch_rready_i),
    .fetch_rdata_o  (fetch_rdata_o),
    .fetch_rresp_o  (fetch_rresp_o),
    .data_way0      (data_if0.ctrl),
    .data_way1      (data_if1.ctrl),
    .tag_way0       (tag_if0.ctrl),
    .tag_way1       (tag_if1.ctrl),
    .rf             (rf_if.master)
  );

  icache_refill i_icache_refill (
    .clk            (clk),
    .rst            (rst),
    .rf             (rf_if.slave),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_r_resp_i   (mem_r_resp_i)
  );

  icache_sram #(.entry_t(mem_pkg::word_t)) i_data_way0 (.clk(clk), .bus(data_if0.ram));
  icache_sram #(.entry_t(mem_pkg::word_t)) i_data_way1 (.clk(clk), .bus(data_if1.ram));

  icache_sram #(.entry_t(icache_pkg::tag_entry_t)) i_tag_way0 (.clk(clk), .bus(tag_if0.ram));
  icache_sram #(.entry_t(icache_pkg::tag_entry_t)) i_tag_way1 (.clk(clk), .bus(tag_if1.ram));

endmodule

/* tests/tb_mem_model.sv */
// memory slave for the cache testbench: answers each read with address ^ key,
// random stalls on both channels, slave error in the top 4 KiB
module tb_mem_model #(
  parameter mem_pkg::word_t DATA_KEY = 64'h5eed_c0de_a5a5_0000,
  parameter mem_pkg::addr_t ERR_BASE = 32'hffff_f000,
  parameter logic [31:0]    SEED     = 32'hf645_ce49
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           ar_valid_i,
  output logic           ar_ready_o,
  input  mem_pkg::addr_t ar_addr_i,
  output logic           r_valid_o,
  input  logic           r_ready_i,
  output mem_pkg::word_t r_data_o,
  output mem_pkg::resp_t r_resp_o,
  output int unsigned    ar_count_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0]    rng_q;
  logic           pending_q;  // address taken, data not yet offered
  logic [1:0]     delay_q;
  mem_pkg::addr_t addr_q;
  mem_pkg::addr_t addr_s;
  logic           ar_fire;
  logic           r_fire;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_resp_o   = mem_pkg::RESP_OKAY;
    ar_count_o = 0;
    pending_q  = 1'b0;
    delay_q    = 2'd0;
    addr_q     = '0;
    rng_q      = SEED;
    forever begin
      @(negedge clk);  // handshake values as seen by the next edge
      ar_fire = ar_valid_i && ar_ready_o;
      r_fire  = r_valid_o && r_ready_i;
      addr_s  = ar_addr_i;
      @(posedge clk);
      #2;
      rng_q = lcg_next(rng_q);
      if (rst) begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        pending_q  = 1'b0;
      end else begin
        if (ar_fire) begin
          pending_q  = 1'b1;
          addr_q     = addr_s;
          delay_q    = rng_q[31:30];  // 0 to 3 cycles before data
          ar_count_o = ar_count_o + 1;
        end
        if (r_fire) r_valid_o = 1'b0;
        if (pending_q && !r_valid_o) begin
          if (delay_q == 2'd0) begin
            r_valid_o = 1'b1;
            r_data_o  = mem_pkg::word_t'(addr_q) ^ DATA_KEY;
            r_resp_o  = (addr_q >= ERR_BASE) ? mem_pkg::RESP_ERR : mem_pkg::RESP_OKAY;
            pending_q = 1'b0;
          end else begin
            delay_q = delay_q - 2'd1;
          end
        end
        ar_ready_o = !pending_q && !r_valid_o && (rng_q[29] | rng_q[28]);
      end
    end
  end

endmodule

/* tests/tb_icache.sv */
// testbench for the instruction cache, replays fetches from the stimulus file
// and checks data word, response and memory refill count of every fetch
module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam string      STIM_FILE        = "tests/icache_stimulus.txt";
  localparam int         CYCLES_PER_FETCH = 200;
  localparam logic [1:0] REFILL_ANY       = 2'd2;  // way choice unknown

  logic           clk;
  logic           rst;
  logic           fetch_valid;
  logic           fetch_ready;
  mem_pkg::addr_t fetch_addr;
  logic           fetch_rvalid;
  logic           fetch_rready;
  mem_pkg::word_t fetch_rdata;
  mem_pkg::resp_t fetch_rresp;
  logic           mem_ar_valid;
  logic           mem_ar_ready;
  mem_pkg::addr_t mem_ar_addr;
  logic           mem_r_valid;
  logic           mem_r_ready;
  mem_pkg::word_t mem_r_data;
  mem_pkg::resp_t mem_r_resp;
  int unsigned    ar_count;

  mem_pkg::addr_t stim_addr[$];
  mem_pkg::word_t stim_word[$];
  mem_pkg::resp_t stim_resp[$];
  logic [1:0]     stim_refill[$];
  int             num_fetches;
  logic           loaded;
  logic [31:0]    rng_q;
  int             word_errs;
  int             resp_errs;
  int             refill_errs;
  int             proto_errs;

  icache_top i_icache_top (
    .clk(clk), .rst(rst),
    .fetch_valid_i(fetch_valid), .fetch_ready_o(fetch_ready), .fetch_addr_i(fetch_addr),
    .fetch_rvalid_o(fetch_rvalid), .fetch_rready_i(fetch_rready),
    .fetch_rdata_o(fetch_rdata), .fetch_rresp_o(fetch_rresp),
    .mem_ar_valid_o(mem_ar_valid), .mem_ar_ready_i(mem_ar_ready), .mem_ar_addr_o(mem_ar_addr),
    .mem_r_valid_i(mem_r_valid), .mem_r_ready_o(mem_r_ready),
    .mem_r_data_i(mem_r_data), .mem_r_resp_i(mem_r_resp)
  );

  tb_mem_model i_mem_model (
    .clk(clk), .rst(rst),
    .ar_valid_i(mem_ar_valid), .ar_ready_o(mem_ar_ready), .ar_addr_i(mem_ar_addr),
    .r_valid_o(mem_r_valid), .r_ready_i(mem_r_ready),
    .r_data_o(mem_r_data), .r_resp_o(mem_r_resp), .ar_count_o(ar_count)
  );

  always #20 clk = ~clk;  // 40 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_word(input string name, input mem_pkg::word_t got,
                            input mem_pkg::word_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input mem_pkg::resp_t got,
                            input mem_pkg::resp_t exp);
    if (got !== exp) begin
      resp_errs++;
      $display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_refill(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      refill_errs++;
      $display("Error at %0t ns: %s = %0b, expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic load_stimulus();
    int             fd;
    string          line;
    mem_pkg::addr_t a;
    mem_pkg::word_t w;
    mem_pkg::resp_t r;
    logic [1:0]     f;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h", a, w, r, f) == 4) begin  // skips comments
          stim_addr.push_back(a);
          stim_word.push_back(w);
          stim_resp.push_back(r);
          stim_refill.push_back(f);
        end
      end
      $fclose(fd);
    end
    num_fetches = stim_addr.size();
  endtask

  // one fetch: address handshake, stalled response, then refill count
  task automatic run_fetch(input int idx);
    int unsigned count_before;
    int unsigned reads;
    logic        done;
    fetch_valid = 1'b1;
    fetch_addr  = stim_addr[idx];
    done        = 1'b0;
    while (!done) begin
      @(negedge clk);
      done         = fetch_ready;
      count_before = ar_count;
      @(posedge clk);
      #2;
    end
    fetch_valid = 1'b0;
    done        = 1'b0;
    while (!done) begin
      rng_q        = lcg_next(rng_q);
      fetch_rready = rng_q[31] | rng_q[30];  // ready about 3 cycles in 4
      @(negedge clk);
      if (fetch_ready) begin
        proto_errs++;
        $display("%0t ns: fetch_ready_o went high before the response of %h was taken",
                 $time, stim_addr[idx]);
      end
      if (fetch_rvalid && fetch_rready) begin
        done  = 1'b1;
        reads = ar_count - count_before;
        check_word("fetch_rdata_o", fetch_rdata, stim_word[idx]);
        check_resp("fetch_rresp_o", fetch_rresp, stim_resp[idx]);
      end
      @(posedge clk);
      #2;
    end
    fetch_rready = 1'b0;
    if (reads > 1) begin
      proto_errs++;
      $display("%0t ns: fetch of %h caused %0d memory reads", $time, stim_addr[idx], reads);
    end else if (stim_refill[idx] != REFILL_ANY) begin
      check_refill("mem_ar refill", reads == 1, stim_refill[idx][0]);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    fetch_valid  = 1'b0;
    fetch_addr   = '0;
    fetch_rready = 1'b0;
    rng_q        = 32'hf645_ce49;
    word_errs    = 0;
    resp_errs    = 0;
    refill_errs  = 0;
    proto_errs   = 0;
    loaded       = 1'b0;
    load_stimulus();
    loaded = 1'b1;
    if (num_fetches == 0) begin
      $display("no fetch could be read from %s", STIM_FILE);
      $display("Simulation failed");
      $finish;
    end else begin
      repeat (10) @(posedge clk);
      #2;
      rst = 1'b0;
      for (int i = 0; i < num_fetches; i++) run_fetch(i);
      repeat (4) @(posedge clk);
      $display("%0d fetches: %0d word, %0d response, %0d refill, %0d protocol errors",
               num_fetches, word_errs, resp_errs, refill_errs, proto_errs);
      if (word_errs + resp_errs + refill_errs + proto_errs == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  // watchdog, scaled by the number of fetches
  initial begin
    wait (loaded);
    repeat (num_fetches * CYCLES_PER_FETCH + 20) @(posedge clk);
    $display("timeout: %0d fetches did not finish in time", num_fetches);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* tests/icache_stimulus.txt */
// fetch address, expected 64-bit word, expected response (0 okay, 2 error),
// refill flag (1 one memory read, 0 none, 2 either)
00001000 5eedc0dea5a51000 0 1
00001004 5eedc0dea5a51000 0 0
00001008 5eedc0dea5a51008 0 1
00001008 5eedc0dea5a51008 0 0
00001010 5eedc0dea5a51010 0 1
00001000 5eedc0dea5a51000 0 0
00002028 5eedc0dea5a52028 0 1
00002228 5eedc0dea5a52228 0 1
00002028 5eedc0dea5a52028 0 2
00002228 5eedc0dea5a52228 0 2
00002028 5eedc0dea5a52028 0 2
fffff100 5eedc0de5a5af100 2 1
fffff104 5eedc0de5a5af100 2 1
fffffff8 5eedc0de5a5afff8 2 1
ffffeff8 5eedc0de5a5aeff8 0 1
ffffeff8 5eedc0de5a5aeff8 0 0
12345678 5eedc0deb7915678 0 1
1234567f 5eedc0deb7915678 0 0
00001008 5eedc0dea5a51008 0 0
00001010 5eedc0dea5a51010 0 0

/* list.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/icache_pkg.sv
verilog/icache_if.sv
verilog/icache_sram.sv
verilog/icache_refill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tests/tb_mem_model.sv
tests/tb_icache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
